//--- bench/fe_asserts.sv
// Bound into the fetch controller, checks that a flush empties IF2 and outputs idle after reset
`timescale 1ns/1ps

module fe_asserts
(
   input logic clk_i,
   input logic reset_i,
   input logic flush_i,
   input logic queue_v_i,
   input logic mem_cmd_v_i,
   input logic fe_cmd_yumi_i
);

   // Count of failed assertions
   int failures = 0;

   // A flush kills IF1 and IF2, so the next cycle has no queue message
   flush_empties_if2: assert property (@(posedge clk_i) disable iff (reset_i)
      flush_i |=> !queue_v_i)
      else
      begin
         $error("Queue valid high in the cycle after a flush");
         failures++;
      end

   // First cycle out of reset is idle
   quiet_after_reset: assert property (@(posedge clk_i)
      $fell(reset_i) |-> !queue_v_i && !mem_cmd_v_i && !fe_cmd_yumi_i)
      else
      begin
         $error("Control outputs active in the cycle after reset");
         failures++;
      end

endmodule

//--- bench/fe_checker.sv
// Expects every accepted command to restart delivery at its vaddr, and only redirects train the BTB
`timescale 1ns/1ps

module fe_checker
   import fe_pkg::*;
   import fe_msg_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  int        test_id_i,
   input  logic      mem_cmd_v_i,
   input  fe_cmd_s   fe_cmd_i,
   input  logic      fe_cmd_v_i,
   input  logic      fe_cmd_yumi_i,
   input  fe_queue_s fe_queue_i,
   input  logic      fe_queue_v_i,
   input  logic      fe_queue_ready_i,
   output int        errors_o,
   output int        checked_o
);

   bit       ref_v [BTB_ENTRIES];
   btb_tag_t ref_tag [BTB_ENTRIES];
   vaddr_t   ref_tgt [BTB_ENTRIES];
   bit       seen_cmd;
   bit       have_expect;
   vaddr_t   expect_pc;

   function automatic string test_name(input int id);
      case (id)
         1: return "idle";
         2: return "sequential";
         3: return "backpressure";
         4: return "icache_miss";
         5: return "btb_train";
         6: return "redirect";
         default: return "reset";
      endcase
   endfunction

   function automatic logic ref_hit(input vaddr_t pc);
      btb_idx_t idx;
      idx = pc[PC_LSB +: BTB_IDX_WIDTH];
      return ref_v[idx] && (ref_tag[idx] == pc[PC_LSB + BTB_IDX_WIDTH +: BTB_TAG_WIDTH]);
   endfunction

   // Next PC after pc, and the word memory holds there
   function automatic vaddr_t expect_next(input vaddr_t pc);
      return ref_hit(pc) ? ref_tgt[pc[PC_LSB +: BTB_IDX_WIDTH]] : pc + vaddr_t'(PC_STEP);
   endfunction

   function automatic instr_t expect_instr(input vaddr_t pc);
      return ~pc;
   endfunction

   task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("FAIL %s %s: expected %h, actual %h", test_name(test_id_i), what, exp, act);
         errors_o++;
      end
   endtask

   task automatic report(input string what);
      $display("%s during test %s", what, test_name(test_id_i));
      errors_o++;
   endtask

   always @(posedge clk_i)
   begin
      if (reset_i)
      begin
         seen_cmd    = 1'b0;
         have_expect = 1'b0;
         ref_v       = '{default: 1'b0};
      end
      else
      begin
         if (!seen_cmd && !fe_cmd_v_i && (mem_cmd_v_i || fe_queue_v_i))
            report("Fetch or queue valid went high before any command");
         if (fe_queue_v_i && !fe_queue_ready_i)
            report("Queue valid was high while ready was low");
         if (fe_cmd_yumi_i && !fe_cmd_v_i)
            report("Command taken while no command was valid");
         if (fe_queue_v_i)
         begin
            if (!have_expect)
               report("Queue message arrived with no command accepted");
            compare("pc", expect_pc, fe_queue_i.pc);
            compare("instr", expect_instr(fe_queue_i.pc), fe_queue_i.instr);
            compare("btb_hit", 32'(ref_hit(fe_queue_i.pc)), 32'(fe_queue_i.btb_hit));
            // Follow the delivered PC so one slip gives one error
            expect_pc = expect_next(fe_queue_i.pc);
            checked_o++;
         end
         if (fe_cmd_v_i)
            seen_cmd = 1'b1;
         if (fe_cmd_yumi_i)
         begin
            expect_pc   = fe_cmd_i.vaddr;
            have_expect = 1'b1;
            if (fe_cmd_i.opcode == e_op_pc_redirect && fe_cmd_i.btb_update != e_btb_none)
            begin
               ref_v[fe_cmd_i.br_pc[PC_LSB +: BTB_IDX_WIDTH]] =
                  (fe_cmd_i.btb_update == e_btb_taken);
               ref_tag[fe_cmd_i.br_pc[PC_LSB +: BTB_IDX_WIDTH]] =
                  fe_cmd_i.br_pc[PC_LSB + BTB_IDX_WIDTH +: BTB_TAG_WIDTH];
               ref_tgt[fe_cmd_i.br_pc[PC_LSB +: BTB_IDX_WIDTH]] = fe_cmd_i.vaddr;
            end
         end
      end
   end

endmodule

//--- bench/tb_fe_pc_gen.sv
// Memory answers each accepted fetch in its IF2 cycle with the inverted address as instruction
`timescale 1ns/1ps

module tb_fe_pc_gen
   import fe_pkg::*;
   import fe_msg_pkg::*;
();

   // Stimulus takes about 1500 cycles, four times that is the limit
   localparam int TIMEOUT_CYCLES = 6000;

   logic      clk_i = 1'b0;
   logic      reset_i;
   vaddr_t    mem_cmd_o;
   logic      mem_cmd_v_o;
   logic      mem_cmd_yumi_i;
   mem_resp_s mem_resp_i;
   logic      mem_resp_v_i;
   fe_cmd_s   fe_cmd_i;
   logic      fe_cmd_v_i;
   logic      fe_cmd_yumi_o;
   fe_queue_s fe_queue_o;
   logic      fe_queue_v_o;
   logic      fe_queue_ready_i;
   logic      rand_ready;
   logic      rand_yumi;
   logic      rand_miss;
   logic      acc_q1;
   logic      acc_q2;
   vaddr_t    addr_q1;
   vaddr_t    addr_q2;
   vaddr_t    jump_pc;
   int        test_id;
   int        cycles;
   int        chk_errors;
   int        chk_checked;
   int        assert_errors;

   fe_pc_gen UUT (.*);

   fe_checker monitor (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .test_id_i        (test_id),
      .mem_cmd_v_i      (mem_cmd_v_o),
      .fe_cmd_i         (fe_cmd_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_yumi_i    (fe_cmd_yumi_o),
      .fe_queue_i       (fe_queue_o),
      .fe_queue_v_i     (fe_queue_v_o),
      .fe_queue_ready_i (fe_queue_ready_i),
      .errors_o         (chk_errors),
      .checked_o        (chk_checked)
   );

   bind fe_fetch_ctrl fe_asserts asserts (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .flush_i       (flush_o),
      .queue_v_i     (queue_v_o),
      .mem_cmd_v_i   (mem_cmd_v_o),
      .fe_cmd_yumi_i (fe_cmd_yumi_o)
   );

   always #10 clk_i = ~clk_i;

   // Instruction stored at an address
   function automatic instr_t mem_word(input vaddr_t addr);
      return ~addr;
   endfunction

   // Accepted fetches, answered in their IF2 cycle
   always @(posedge clk_i)
   begin
      acc_q1  <= ~reset_i & mem_cmd_v_o & mem_cmd_yumi_i;
      addr_q1 <= mem_cmd_o;
      acc_q2  <= ~reset_i & acc_q1;
      addr_q2 <= addr_q1;
   end

   always @(posedge clk_i)
   begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES)
      begin
         $display("Timeout after %0d cycles, the stimulus never finished", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   // One cycle of handshakes and memory response
   task automatic step();
      @(negedge clk_i);
      fe_queue_ready_i       = !rand_ready || ($urandom % 4 != 0);
      mem_cmd_yumi_i         = !rand_yumi || ($urandom % 4 != 0);
      mem_resp_v_i           = acc_q2;
      mem_resp_i.instr       = mem_word(addr_q2);
      mem_resp_i.icache_miss = acc_q2 && rand_miss && ($urandom % 8 == 0);
   endtask

   task automatic run_cycles(input int n);
      repeat (n) step();
   endtask

   // Holds the command until the DUT takes it
   task automatic send_cmd(input fe_opcode_e op, input vaddr_t va, input vaddr_t br,
                           input btb_update_e upd);
      fe_cmd_i   = '{opcode: op, vaddr: va, br_pc: br, btb_update: upd};
      fe_cmd_v_i = 1'b1;
      @(posedge clk_i);
      while (!fe_cmd_yumi_o)
      begin
         step();
         @(posedge clk_i);
      end
      step();
      fe_cmd_v_i = 1'b0;
   endtask

   initial
   begin
      void'($urandom(72536));
      reset_i          = 1'b1;
      fe_cmd_i         = '0;
      fe_cmd_v_i       = 1'b0;
      mem_cmd_yumi_i   = 1'b0;
      mem_resp_i       = '0;
      mem_resp_v_i     = 1'b0;
      fe_queue_ready_i = 1'b1;
      rand_ready       = 1'b0;
      rand_yumi        = 1'b0;
      rand_miss        = 1'b0;
      test_id          = 0;
      repeat (5) @(posedge clk_i);
      step();
      reset_i = 1'b0;
      test_id = 1;
      run_cycles(20);
      test_id = 2;
      send_cmd(e_op_state_reset, 32'h0000_1000, '0, e_btb_none);
      run_cycles(80);
      test_id    = 3;
      rand_ready = 1'b1;
      rand_yumi  = 1'b1;
      run_cycles(300);
      test_id   = 4;
      rand_miss = 1'b1;
      run_cycles(300);
      // Branch at 0x2000 taken to 0x3000, then the entry is cleared
      test_id    = 5;
      rand_ready = 1'b0;
      rand_yumi  = 1'b0;
      rand_miss  = 1'b0;
      send_cmd(e_op_pc_redirect, 32'h0000_3000, 32'h0000_2000, e_btb_taken);
      run_cycles(30);
      send_cmd(e_op_state_reset, 32'h0000_1ff8, '0, e_btb_none);
      run_cycles(60);
      send_cmd(e_op_pc_redirect, 32'h0000_1ff8, 32'h0000_2000, e_btb_clear);
      run_cycles(60);
      test_id    = 6;
      rand_ready = 1'b1;
      rand_yumi  = 1'b1;
      rand_miss  = 1'b1;
      repeat (6)
      begin
         run_cycles(20 + $urandom % 40);
         jump_pc = vaddr_t'($urandom) & ~vaddr_t'(3);
         send_cmd(e_op_pc_redirect, jump_pc, '0, e_btb_none);
      end
      run_cycles(60);
      assert_errors = UUT.ctrl.asserts.failures;
      $display("Errors: %0d checker and %0d assertion in %0d checked queue messages",
               chk_errors, assert_errors, chk_checked);
      if (chk_checked == 0)
         $display("No queue message was delivered during the run");
      if (chk_errors == 0 && assert_errors == 0 && chk_checked > 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

//--- hw/fe_btb.sv
// Only valid bits are reset, and a clear drops whatever entry sits at the branch index
`timescale 1ns/1ps

module fe_btb
   import fe_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   input  vaddr_t r_addr_i,
   output logic   hit_o,
   output vaddr_t tgt_o,
   input  logic   w_v_i,
   input  logic   w_clr_i,
   input  vaddr_t w_pc_i,
   input  vaddr_t w_tgt_i
);

   logic [BTB_ENTRIES-1:0] valid_r;
   btb_tag_t               tag_mem [BTB_ENTRIES];
   vaddr_t                 tgt_mem [BTB_ENTRIES];
   vaddr_t                 r_addr_r;
   btb_idx_t               r_idx;
   btb_tag_t               r_tag;
   btb_idx_t               w_idx;
   btb_tag_t               w_tag;

   // Index sits just above the byte offset, tag right above the index
   assign r_idx = r_addr_r[PC_LSB +: BTB_IDX_WIDTH];
   assign r_tag = r_addr_r[PC_LSB + BTB_IDX_WIDTH +: BTB_TAG_WIDTH];
   assign w_idx = w_pc_i[PC_LSB +: BTB_IDX_WIDTH];
   assign w_tag = w_pc_i[PC_LSB + BTB_IDX_WIDTH +: BTB_TAG_WIDTH];

   // Registered read address gives the answer one cycle later
   always_ff @(posedge clk_i)
   begin
      r_addr_r <= r_addr_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         valid_r <= '0;
      else if (w_v_i)
         valid_r[w_idx] <= ~w_clr_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (w_v_i && !w_clr_i)
      begin
         tag_mem[w_idx] <= w_tag;
         tgt_mem[w_idx] <= w_tgt_i;
      end
   end

   // Lookup reads the table after the write edge, so new entries hit at once
   assign hit_o = valid_r[r_idx] & (tag_mem[r_idx] == r_tag);
   assign tgt_o = tgt_mem[r_idx];

endmodule

//--- hw/fe_fetch_ctrl.sv
// A command must stay valid until accepted, and a missing memory response counts as a cache miss
`timescale 1ns/1ps

module fe_fetch_ctrl
   import fe_pkg::*;
   import fe_msg_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      fe_cmd_v_i,
   input  fe_cmd_s   fe_cmd_i,
   input  logic      mem_cmd_yumi_i,
   input  mem_resp_s mem_resp_i,
   input  logic      mem_resp_v_i,
   input  logic      fe_queue_ready_i,
   input  pc_stage_s if2_i,
   input  logic      if1_next_v_i,
   output logic      flush_o,
   output logic      queue_v_o,
   output logic      mem_cmd_v_o,
   output logic      fe_cmd_yumi_o,
   output vaddr_t    resume_pc_o,
   output logic      running_o,
   output logic      fetch_take_o,
   output logic      btb_w_v_o,
   output logic      btb_w_clr_o
);

   typedef enum logic [1:0] {
      e_wait,
      e_stall,
      e_run
   } fetch_state_e;

   fetch_state_e state_r;
   fetch_state_e state_n;
   logic         icache_miss;
   logic         queue_miss;
   logic         fetch_fail;
   logic         is_wait;

   assign is_wait   = (state_r == e_wait);
   assign running_o = (state_r == e_run);

   // IF2 fails on a miss, on no response at all, or on a full queue
   assign icache_miss = if2_i.v & (~mem_resp_v_i | mem_resp_i.icache_miss);
   assign queue_miss  = if2_i.v & ~fe_queue_ready_i;
   assign flush_o     = fe_cmd_v_i | icache_miss | queue_miss;
   assign queue_v_o   = fe_queue_ready_i & if2_i.v & ~flush_o;
   assign fetch_fail  = if2_i.v & ~queue_v_o;

   // A pending command always fetches its own address
   assign mem_cmd_v_o   = fe_cmd_v_i | (~is_wait & fe_queue_ready_i & ~flush_o);
   assign fe_cmd_yumi_o = fe_cmd_v_i & mem_cmd_yumi_i;
   assign fetch_take_o  = mem_cmd_v_o & mem_cmd_yumi_i;

   // BTB training rides on an accepted redirect
   assign btb_w_v_o   = fe_cmd_yumi_o & (fe_cmd_i.opcode == e_op_pc_redirect)
                        & (fe_cmd_i.btb_update != e_btb_none);
   assign btb_w_clr_o = (fe_cmd_i.btb_update == e_btb_clear);

   always_comb
   begin
      case (state_r)
         // A command taken straight away skips the stall
         e_wait:  state_n = fe_cmd_v_i ? (if1_next_v_i ? e_run : e_stall) : e_wait;
         e_stall: state_n = if1_next_v_i ? e_run : e_stall;
         e_run:   state_n = (fetch_fail & ~fe_cmd_v_i) ? e_stall : e_run;
         default: state_n = e_wait;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= e_wait;
      else
         state_r <= state_n;
   end

   // Restart point after a stall
   always_ff @(posedge clk_i)
   begin
      if (fe_cmd_v_i)
         resume_pc_o <= fe_cmd_i.vaddr;
      else if (running_o)
         resume_pc_o <= if2_i.pc;
   end

endmodule

//--- hw/fe_msg_pkg.sv
// Struct layouts have no padding and the opcode and BTB update encodings must match the backend
package fe_msg_pkg;

   import fe_pkg::*;

   // Frontend command opcodes
   typedef enum logic {
      e_op_state_reset,
      e_op_pc_redirect
   } fe_opcode_e;

   // BTB training carried by a redirect
   typedef enum logic [1:0] {
      e_btb_none,
      e_btb_taken,
      e_btb_clear
   } btb_update_e;

   // Command from the backend, vaddr is both restart address and branch target
   typedef struct packed {
      fe_opcode_e  opcode;
      vaddr_t      vaddr;
      vaddr_t      br_pc;
      btb_update_e btb_update;
   } fe_cmd_s;

   typedef struct packed {
      instr_t instr;
      logic   icache_miss;
   } mem_resp_s;

   // Message pushed into the frontend queue
   typedef struct packed {
      vaddr_t pc;
      instr_t instr;
      logic   btb_hit;
   } fe_queue_s;

   // One fetch pipeline stage
   typedef struct packed {
      logic   v;
      vaddr_t pc;
      logic   btb_hit;
   } pc_stage_s;

endpackage

//--- hw/fe_pc_gen.sv
// Memory must answer each accepted fetch in the cycle that fetch sits in IF2, two edges later
`timescale 1ns/1ps

module fe_pc_gen
   import fe_pkg::*;
   import fe_msg_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,

   output vaddr_t    mem_cmd_o,
   output logic      mem_cmd_v_o,
   input  logic      mem_cmd_yumi_i,

   input  mem_resp_s mem_resp_i,
   input  logic      mem_resp_v_i,

   input  fe_cmd_s   fe_cmd_i,
   input  logic      fe_cmd_v_i,
   output logic      fe_cmd_yumi_o,

   output fe_queue_s fe_queue_o,
   output logic      fe_queue_v_o,
   input  logic      fe_queue_ready_i
);

   logic      flush;
   logic      running;
   logic      fetch_take;
   logic      btb_w_v;
   logic      btb_w_clr;
   logic      if1_next_v;
   logic      btb_hit;
   vaddr_t    btb_tgt;
   vaddr_t    resume_pc;
   pc_stage_s if2;

   fe_fetch_ctrl ctrl (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_i         (fe_cmd_i),
      .mem_cmd_yumi_i   (mem_cmd_yumi_i),
      .mem_resp_i       (mem_resp_i),
      .mem_resp_v_i     (mem_resp_v_i),
      .fe_queue_ready_i (fe_queue_ready_i),
      .if2_i            (if2),
      .if1_next_v_i     (if1_next_v),
      .flush_o          (flush),
      .queue_v_o        (fe_queue_v_o),
      .mem_cmd_v_o      (mem_cmd_v_o),
      .fe_cmd_yumi_o    (fe_cmd_yumi_o),
      .resume_pc_o      (resume_pc),
      .running_o        (running),
      .fetch_take_o     (fetch_take),
      .btb_w_v_o        (btb_w_v),
      .btb_w_clr_o      (btb_w_clr)
   );

   fe_pc_pipe pipe (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .fe_cmd_i     (fe_cmd_i),
      .cmd_take_i   (fe_cmd_yumi_o),
      .fetch_take_i (fetch_take),
      .running_i    (running),
      .flush_i      (flush),
      .resume_pc_i  (resume_pc),
      .btb_hit_i    (btb_hit),
      .btb_tgt_i    (btb_tgt),
      .mem_resp_i   (mem_resp_i),
      .next_pc_o    (mem_cmd_o),
      .if1_next_v_o (if1_next_v),
      .if2_o        (if2),
      .fe_queue_o   (fe_queue_o)
   );

   // Read with the address sent to memory so the result lines up with IF1
   fe_btb btb (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .r_addr_i (mem_cmd_o),
      .hit_o    (btb_hit),
      .tgt_o    (btb_tgt),
      .w_v_i    (btb_w_v),
      .w_clr_i  (btb_w_clr),
      .w_pc_i   (fe_cmd_i.br_pc),
      .w_tgt_i  (fe_cmd_i.vaddr)
   );

endmodule

//--- hw/fe_pc_pipe.sv
// Every fetch reaches IF2 two edges after acceptance, and a fetch not accepted is retried
`timescale 1ns/1ps

module fe_pc_pipe
   import fe_pkg::*;
   import fe_msg_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  fe_cmd_s   fe_cmd_i,
   input  logic      cmd_take_i,
   input  logic      fetch_take_i,
   input  logic      running_i,
   input  logic      flush_i,
   input  vaddr_t    resume_pc_i,
   input  logic      btb_hit_i,
   input  vaddr_t    btb_tgt_i,
   input  mem_resp_s mem_resp_i,
   output vaddr_t    next_pc_o,
   output logic      if1_next_v_o,
   output pc_stage_s if2_o,
   output fe_queue_s fe_queue_o
);

   logic      if1_v_r;
   vaddr_t    if1_pc_r;
   pc_stage_s if1;
   pc_stage_s if2_r;
   pc_stage_s if2_n;

   // The BTB answer for the IF1 address arrives in the IF1 cycle
   always_comb
   begin
      if1.v       = if1_v_r;
      if1.pc      = if1_pc_r;
      if1.btb_hit = btb_hit_i;
   end

   // Next fetch address in priority order
   always_comb
   begin
      if (cmd_take_i)
         next_pc_o = fe_cmd_i.vaddr;
      else if (!running_i)
         next_pc_o = resume_pc_i;
      // IF1 holds the address that memory refused last cycle
      else if (!if1.v)
         next_pc_o = if1.pc;
      else if (if1.btb_hit)
         next_pc_o = btb_tgt_i;
      else
         next_pc_o = if1.pc + vaddr_t'(PC_STEP);
   end

   assign if1_next_v_o = fetch_take_i;

   always_comb
   begin
      if2_n   = if1;
      if2_n.v = if1.v & ~flush_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         if1_v_r <= 1'b0;
         if2_r.v <= 1'b0;
      end
      else
      begin
         if1_v_r  <= fetch_take_i;
         if1_pc_r <= next_pc_o;
         if2_r    <= if2_n;
      end
   end

   assign if2_o = if2_r;

   // Queue message from IF2 and the memory response
   always_comb
   begin
      fe_queue_o.pc      = if2_r.pc;
      fe_queue_o.instr   = mem_resp_i.instr;
      fe_queue_o.btb_hit = if2_r.btb_hit;
   end

endmodule

//--- hw/fe_pkg.sv
// Fetch is 32 bits wide and word aligned, and the BTB is direct mapped with 16 entries
package fe_pkg;

   // Address and instruction widths
   localparam int VADDR_WIDTH = 32;
   localparam int INSTR_WIDTH = 32;

   // BTB geometry
   localparam int BTB_IDX_WIDTH = 4;
   localparam int BTB_TAG_WIDTH = 8;
   localparam int BTB_ENTRIES   = 1 << BTB_IDX_WIDTH;

   // Sequential fetch step and lowest address bit used for BTB indexing
   localparam int PC_STEP = 4;
   localparam int PC_LSB  = 2;

   typedef logic [VADDR_WIDTH-1:0]   vaddr_t;
   typedef logic [INSTR_WIDTH-1:0]   instr_t;
   typedef logic [BTB_IDX_WIDTH-1:0] btb_idx_t;
   typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;

endpackage

//--- tb.f
hw/fe_pkg.sv
hw/fe_msg_pkg.sv
hw/fe_btb.sv
hw/fe_fetch_ctrl.sv
hw/fe_pc_pipe.sv
hw/fe_pc_gen.sv
bench/fe_asserts.sv
bench/fe_checker.sv
bench/tb_fe_pc_gen.sv
